/* verif/predecoder_cases.txt */
# B startOffset(hex) endBits(hex) parcels(hex, parcel 14 first)
# I word(hex) offset length class(jump indir alu shift mul load store fpu sys) last; T truncated
B 0 7fff 002F0025010100820041001F0020003F0034003300300014001500130000
I 00130000 0 1 001000000 0
I 00150013 1 1 001000000 0
I 00140015 2 1 000100000 0
I 00300014 3 1 000000000 0
I 00330030 4 1 100000000 0
I 00340033 5 1 100000000 0
I 003F0034 6 1 000000010 0
I 0020003F 7 1 000000010 0
I 001F0020 8 1 000000000 0
I 0041001F 9 1 000100000 0
I 00820041 10 1 001000000 0
I 01010082 11 1 001000000 0
I 00250101 12 1 001000000 0
I 002F0025 13 1 000000000 0
I 0000002F 14 1 000000000 1
T 0
B 3 4d37 EEEEDDDD34F0003200AA00B588887777002A0009BEEF1A05333322221111
I BEEF1A05 3 2 000010000 0
I 002A0009 5 1 001000000 0
I 7777002A 6 3 000100000 0
I 00AA00B5 9 2 100000000 0
I 34F00032 11 1 100000000 0
I DDDD34F0 12 3 000000010 1
T 0
B 0 6aaa 0010000799FF000600F000050024000455B6000300A30002338200011241
I 00011241 0 2 000000100 0
I 00023382 2 2 000001000 0
I 000300A3 4 2 101000000 0
I 000455B6 6 2 110000000 0
I 00050024 8 2 000010000 0
I 000600F0 10 2 000000010 0
I 000799FF 12 2 000000001 0
I 00000010 14 1 001000000 1
T 0
B 0 0005 00FFCCCC01280011
I 01280011 0 1 001000000 0
I CCCC0128 1 2 000100000 1
T 1
B 5 000f 0
T 1
B d 4000 123400FF0000000000000000000000000000000000000000000000000000
I 123400FF 13 2 000000001 1
T 0

/* compile.f */
common/isaPkg.sv
common/bundlePkg.sv
src/instrClassifier.sv
src/bundleSlicer.sv
src/itemQueue.sv
src/itemSerializer.sv
src/predecoderTop.sv
verif/predecoderTb.sv

/* Bender.yml */
package:
  name: predecoder

sources:
  - common/isaPkg.sv
  - common/bundlePkg.sv
  - src/instrClassifier.sv
  - src/bundleSlicer.sv
  - src/itemQueue.sv
  - src/itemSerializer.sv
  - src/predecoderTop.sv
  - target: simulation
    files:
      - verif/predecoderTb.sv

/* verif/predecoderTb.sv */
module predecoderTb import isaPkg::*, bundlePkg::*; ();

  localparam int IdleLimit = 200;
  localparam int DrainCycles = 40;

  logic   clk;
  logic   reset;
  logic   inValid;
  bundleT inBundle;
  logic   inReady;
  logic   outValid;
  itemT   outItem;
  logic   outTruncated;
  logic   outReady;

  bundleT caseBundle[$];
  bit     caseTrunc[$];
  int     caseItemCount[$];
  itemT   expItem[$];
  int     expCase[$];

  int errorCount = 0;
  int testsRun = 0;
  int testsFailed = 0;
  int seedValue;

  predecoderTop #(.QueueDepth(4)) DUT (
    .clk          (clk),
    .reset        (reset),
    .inValid      (inValid),
    .inBundle     (inBundle),
    .inReady      (inReady),
    .outValid     (outValid),
    .outItem      (outItem),
    .outTruncated (outTruncated),
    .outReady     (outReady)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic readCases();
    int fd;
    int code;
    string line;
    logic [3:0] start;
    logic [14:0] ends;
    logic [239:0] parcelBits;
    logic [31:0] word;
    int offset;
    int length;
    logic [8:0] cls;
    int last;
    int trunc;
    itemT item;
    bundleT bundle;
    fd = $fopen("verif/predecoder_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file");
      return;
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code == 0 || line.len() < 2) continue;
      if (line.substr(0, 0) == "B") begin
        code = $sscanf(line, "B %h %h %h", start, ends, parcelBits);
        bundle.startOffset = start;
        bundle.endBits = ends;
        bundle.parcels = parcelBits;
        caseBundle.push_back(bundle);
        caseTrunc.push_back(1'b0);
        caseItemCount.push_back(0);
      end else if (line.substr(0, 0) == "I") begin
        code = $sscanf(line, "I %h %d %d %b %d", word, offset, length, cls, last);
        item.word = word;
        item.offset = offsetT'(offset);
        item.length = 2'(length);
        item.instrClass = cls;
        item.lastInBundle = last[0];
        expItem.push_back(item);
        expCase.push_back(caseBundle.size() - 1);
        caseItemCount[caseItemCount.size() - 1]++;
      end else if (line.substr(0, 0) == "T") begin
        code = $sscanf(line, "T %d", trunc);
        caseTrunc[caseTrunc.size() - 1] = trunc[0];
      end
    end
    $fclose(fd);
  endtask

  task automatic checkItem(input itemT got, input itemT exp, input int index);
    if (got !== exp) begin
      $display("error: outItem item %0d got %h expected %h", index, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkTruncated(input bit got, input bit exp, input int index);
    if (got !== exp) begin
      $display("error: outTruncated item %0d got %h expected %h", index, got, exp);
      errorCount++;
    end
  endtask

  task automatic reportCase(input int passNo, input int caseNo, input bit ok);
    testsRun++;
    if (ok) begin
      $display("pass %0d case %0d: ok", passNo, caseNo);
    end else begin
      testsFailed++;
      $display("pass %0d case %0d: failed", passNo, caseNo);
    end
  endtask

  // Sends the case list reps times back to back and checks the item stream.
  task automatic runPass(input int passNo, input bit stall, input int reps);
    int sent;
    int received;
    int idle;
    int caseNo;
    int caseErrors;
    int totalCases;
    int totalItems;
    bit sawBusy;
    bit expTrunc;
    sent = 0;
    received = 0;
    idle = 0;
    caseErrors = errorCount;
    sawBusy = 0;
    totalCases = caseBundle.size() * reps;
    totalItems = expItem.size() * reps;
    while ((sent < totalCases || received < totalItems) && idle < IdleLimit) begin
      @(negedge clk);
      outReady = stall ? ($urandom_range(3) != 0) : 1'b1;
      if (sent < totalCases) begin
        inValid = 1'b1;
        inBundle = caseBundle[sent % caseBundle.size()];
      end else begin
        inValid = 1'b0;
        inBundle = '0;
      end
      #1;
      idle++;
      if (!inReady) sawBusy = 1;
      if (inValid && inReady) begin
        idle = 0;
        // A bundle without complete instructions finishes on acceptance.
        if (caseItemCount[sent % caseBundle.size()] == 0) begin
          reportCase(passNo, sent % caseBundle.size(), 1'b1);
        end
        sent++;
      end
      if (outValid && outReady) begin
        idle = 0;
        if (received >= totalItems) begin
          $display("an extra item appeared after all expected items");
          errorCount++;
        end else begin
          caseNo = expCase[received % expItem.size()];
          if (received % expItem.size() == 0 ||
              expCase[received % expItem.size() - 1] != caseNo) begin
            caseErrors = errorCount;
          end
          expTrunc = caseTrunc[caseNo] && expItem[received % expItem.size()].lastInBundle;
          checkItem(outItem, expItem[received % expItem.size()], received);
          checkTruncated(outTruncated, expTrunc, received);
          if (expItem[received % expItem.size()].lastInBundle) begin
            reportCase(passNo, caseNo, errorCount == caseErrors);
          end
          received++;
        end
      end
    end
    if (idle >= IdleLimit) begin
      $display("timeout in pass %0d: %0d bundles sent, %0d items received",
               passNo, sent, received);
      errorCount++;
    end
    inValid = 1'b0;
    idle = 0;
    while (idle < DrainCycles) begin
      @(negedge clk);
      #1;
      idle++;
      if (outValid) begin
        $display("pass %0d delivered an item nobody expected", passNo);
        errorCount++;
        idle = DrainCycles;
      end
    end
    if (stall && !sawBusy) begin
      $display("inReady never dropped while the queue was full");
      errorCount++;
    end
  endtask

  initial begin
    seedValue = $urandom(74);
    reset = 1'b1;
    inValid = 1'b0;
    inBundle = '0;
    outReady = 1'b0;
    readCases();
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    if (caseBundle.size() == 0) begin
      $display("no test cases could be read");
      errorCount++;
    end else begin
      runPass(1, 1'b0, 1);
      runPass(2, 1'b1, 2);
    end
    $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
    if (errorCount == 0 && testsFailed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* src/predecoderTop.sv */
module predecoderTop import bundlePkg::*; #(
  parameter int QueueDepth = 4
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   inValid,
  input  bundleT inBundle,
  output logic   inReady,
  output logic   outValid,
  output itemT   outItem,
  output logic   outTruncated,
  input  logic   outReady
);

  logic          sliceValid;
  logic          sliceReady;
  decodedBundleT slice;
  logic          headValid;
  logic          headReady;
  decodedBundleT head;

  bundleSlicer slicer (
    .clk        (clk),
    .reset      (reset),
    .inValid    (inValid),
    .inBundle   (inBundle),
    .inReady    (inReady),
    .sliceValid (sliceValid),
    .slice      (slice),
    .sliceReady (sliceReady)
  );

  itemQueue #(
    .Depth (QueueDepth)
  ) queue (
    .clk        (clk),
    .reset      (reset),
    .sliceValid (sliceValid),
    .slice      (slice),
    .sliceReady (sliceReady),
    .headValid  (headValid),
    .head       (head),
    .headReady  (headReady)
  );

  itemSerializer serializer (
    .clk          (clk),
    .reset        (reset),
    .headValid    (headValid),
    .head         (head),
    .headReady    (headReady),
    .outValid     (outValid),
    .outItem      (outItem),
    .outTruncated (outTruncated),
    .outReady     (outReady)
  );

endmodule

/* src/itemSerializer.sv */
module itemSerializer import bundlePkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          headValid,
  input  decodedBundleT head,
  output logic          headReady,
  output logic          outValid,
  output itemT          outItem,
  output logic          outTruncated,
  input  logic          outReady
);

  logic [3:0] itemIndex;
  logic       transfer;

  assign outValid = headValid;
  assign outItem  = head.items[itemIndex];

  // Truncation is reported once with the bundle's final item.
  assign outTruncated = head.truncated && outItem.lastInBundle;

  assign transfer  = outValid && outReady;
  assign headReady = transfer && outItem.lastInBundle;

  always_ff @(posedge clk) begin
    if (reset) begin
      itemIndex <= '0;
    end else if (headReady) begin
      itemIndex <= '0;
    end else if (transfer) begin
      itemIndex <= itemIndex + 4'd1;
    end
  end

endmodule

/* src/itemQueue.sv */
module itemQueue import bundlePkg::*; #(
  parameter int Depth = 4
) (
  input  logic          clk,
  input  logic          reset,
  input  logic          sliceValid,
  input  decodedBundleT slice,
  output logic          sliceReady,
  output logic          headValid,
  output decodedBundleT head,
  input  logic          headReady
);

  localparam int PtrWidth   = $clog2(Depth);
  localparam int CountWidth = $clog2(Depth + 1);

  decodedBundleT mem [Depth];

  logic [PtrWidth-1:0]   rdPtr;
  logic [PtrWidth-1:0]   wrPtr;
  logic [CountWidth-1:0] count;
  logic                  full;
  logic                  doWrite;
  logic                  doRead;

  // Wrap explicitly so any depth works.
  function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full       = count == CountWidth'(Depth);
  assign sliceReady = !full || headReady;
  assign headValid  = count != '0;
  assign head       = mem[rdPtr];

  assign doWrite = sliceValid && sliceReady;
  assign doRead  = headValid && headReady;

  always_ff @(posedge clk) begin
    if (reset) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (doWrite) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (doRead) begin
        rdPtr <= nextPtr(rdPtr);
      end
      count <= count + CountWidth'(doWrite) - CountWidth'(doRead);
    end
  end

  always_ff @(posedge clk) begin
    if (doWrite) begin
      mem[wrPtr] <= slice;
    end
  end

endmodule

/* src/bundleSlicer.sv */
module bundleSlicer import isaPkg::*, bundlePkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          inValid,
  input  bundleT        inBundle,
  output logic          inReady,
  output logic          sliceValid,
  output decodedBundleT slice,
  input  logic          sliceReady
);

  parcelT [ParcelCount:0]     parcelsExt;
  logic   [ParcelCount:0]     endExt;
  logic   [ParcelCount-1:0]   isStart;
  logic   [ParcelCount-1:0]   complete;
  instrWordT [ParcelCount-1:0]  words;
  instrClassT [ParcelCount-1:0] classes;
  itemT   [ParcelCount-1:0]   items;
  decodedBundleT              nextSlice;
  logic   [3:0]               itemCount;

  // One zero parcel past the end lets the last slot see two parcels.
  assign parcelsExt = {parcelT'(0), inBundle.parcels};
  assign endExt     = {1'b0, inBundle.endBits};

  for (genvar k = 0; k < ParcelCount; k++) begin : gSlot
    formT       form;
    logic [1:0] length;

    if (k == 0) begin : gFirst
      assign isStart[k] = inBundle.startOffset == offsetT'(k);
    end else begin : gRest
      assign isStart[k] = inBundle.startOffset == offsetT'(k) ||
          (inBundle.startOffset < offsetT'(k) && endExt[k-1]);
    end

    // Complete when some end bit lies at or after this parcel.
    assign complete[k] = |inBundle.endBits[ParcelCount-1:k];

    assign form   = ~endExt[k+1:k];
    assign length = endExt[k] ? 2'd1 : (endExt[k+1] ? 2'd2 : 2'd3);

    assign words[k] = {parcelsExt[k+1], parcelsExt[k]};

    instrClassifier classifier (
      .word       (words[k]),
      .form       (form),
      .instrClass (classes[k])
    );

    assign items[k] = '{word: words[k], offset: offsetT'(k), length: length,
                        instrClass: classes[k], lastInBundle: 1'b0};
  end

  // Compact the starts into program order.
  always_comb begin
    nextSlice = '0;
    itemCount = '0;
    for (int k = 0; k < ParcelCount; k++) begin
      if (isStart[k] && complete[k]) begin
        nextSlice.items[itemCount] = items[k];
        itemCount = itemCount + 4'd1;
      end
    end
    if (itemCount != 4'd0) begin
      nextSlice.items[itemCount - 4'd1].lastInBundle = 1'b1;
    end
    nextSlice.count     = itemCount;
    nextSlice.truncated = |(isStart & ~complete);
  end

  assign inReady = !sliceValid || sliceReady;

  // An empty bundle is taken but leaves the register empty.
  always_ff @(posedge clk) begin
    if (reset) begin
      sliceValid <= 1'b0;
    end else if (inReady) begin
      sliceValid <= inValid && nextSlice.count != 4'd0;
    end
  end

  always_ff @(posedge clk) begin
    if (inValid && inReady) begin
      slice <= nextSlice;
    end
  end

endmodule

/* src/instrClassifier.sv */
module instrClassifier import isaPkg::*; (
  input  instrWordT  word,
  input  formT       form,
  output instrClassT instrClass
);

  logic [7:0] opcode;
  logic [5:0] subOpcode;
  logic       isLong;

  logic longAluMul;
  logic longShift;
  logic longCmp;
  logic longLoadStore;
  logic longCondJump;
  logic longJump;
  logic longIndir;
  logic longFpu;
  logic longSys;

  logic shortAlu;
  logic shortShift;
  logic shortJump;
  logic shortFpu;

  assign opcode    = word.longForm.opcode;
  assign subOpcode = word.shortForm.subOpcode;

  // A first parcel without an end bit marks the long form.
  assign isLong = form[0];

  assign longAluMul = isLong && opcode <= OpAluMulLast;

  assign longShift = isLong && opcode >= OpShiftFirst && opcode <= OpShiftLast;

  assign longCmp = isLong && opcode >= OpCmpFirst && opcode <= OpCmpLast;

  // Base and indexed addressing blocks.
  assign longLoadStore = isLong &&
      ((opcode >= OpBaseLsFirst && opcode <= OpBaseLsLast) ||
       (opcode >= OpIndexLsFirst && opcode <= OpIndexLsLast));

  assign longCondJump = isLong && opcode >= OpCondJumpFirst && opcode <= OpCondJumpLast;

  assign longJump  = isLong && opcode == OpJump;
  assign longIndir = isLong && opcode == OpIndirJump;
  assign longFpu   = isLong && opcode == OpFpuScalar;
  assign longSys   = isLong && opcode == OpSystem;

  assign shortAlu = !isLong && subOpcode <= SubAluLast;

  // Odd sub-opcodes between the ALU block and 32.
  assign shortShift = !isLong && subOpcode > SubAluLast && subOpcode <= SubShiftLast &&
      subOpcode[0];

  assign shortJump = !isLong && subOpcode >= SubJumpFirst && subOpcode <= SubJumpLast;

  assign shortFpu = !isLong && subOpcode >= SubFpuFirst;

  always_comb begin
    instrClass = '0;

    instrClass.jump  = longCondJump || longJump || longIndir || shortJump;
    instrClass.indir = longIndir;

    // Conditional jumps also use the ALU for the compare.
    instrClass.alu = (longAluMul && !opcode[AluMulSelectBit]) || longCmp ||
        longCondJump || shortAlu;

    instrClass.shift = longShift || shortShift;
    instrClass.mul   = longAluMul && opcode[AluMulSelectBit];

    instrClass.load  = longLoadStore && !opcode[0];
    instrClass.store = longLoadStore && opcode[0];

    instrClass.fpu = longFpu || shortFpu;
    instrClass.sys = longSys;
  end

endmodule

/* common/bundlePkg.sv */
package bundlePkg;

  import isaPkg::*;

  localparam int ParcelCount = 15;

  typedef logic [3:0] offsetT;

  // Parcels sit in the low bits and the end bits above them.
  typedef struct packed {
    offsetT                  startOffset;
    logic [ParcelCount-1:0]  endBits;
    parcelT [ParcelCount-1:0] parcels;
  } bundleT;

  // Length in parcels where 3 also stands for anything longer.
  typedef struct packed {
    instrWordT  word;
    offsetT     offset;
    logic [1:0] length;
    instrClassT instrClass;
    logic       lastInBundle;
  } itemT;

  // Items are packed from index 0 in program order.
  typedef struct packed {
    logic                   truncated;
    logic [3:0]             count;
    itemT [ParcelCount-1:0] items;
  } decodedBundleT;

endpackage

/* common/isaPkg.sv */
package isaPkg;

  typedef logic [15:0] parcelT;

  // Long form with its main opcode in the low byte of the first parcel.
  typedef struct packed {
    logic [23:0] fields;
    logic [7:0]  opcode;
  } longFormT;

  // One-parcel short form with a 6-bit sub-opcode.
  typedef struct packed {
    logic [25:0] fields;
    logic [5:0]  subOpcode;
  } shortFormT;

  // First two parcels of an instruction with parcel 0 in the low half.
  typedef union packed {
    longFormT  longForm;
    shortFormT shortForm;
  } instrWordT;

  // Bit 0 means the first parcel is not the last and bit 1 means the same for the second.
  typedef logic [1:0] formT;

  typedef struct packed {
    logic jump;
    logic indir;
    logic alu;
    logic shift;
    logic mul;
    logic load;
    logic store;
    logic fpu;
    logic sys;
  } instrClassT;

  // Long-form main opcodes.
  localparam logic [7:0] OpAluMulLast      = 8'd39;
  localparam logic [7:0] OpShiftFirst      = 8'd40;
  localparam logic [7:0] OpShiftLast       = 8'd45;
  localparam logic [7:0] OpCmpFirst        = 8'd46;
  localparam logic [7:0] OpCmpLast         = 8'd53;
  localparam logic [7:0] OpBaseLsFirst     = 8'd64;
  localparam logic [7:0] OpBaseLsLast      = 8'd127;
  localparam logic [7:0] OpIndexLsFirst    = 8'd128;
  localparam logic [7:0] OpIndexLsLast     = 8'd159;
  localparam logic [7:0] OpCondJumpFirst   = 8'd160;
  localparam logic [7:0] OpCondJumpLast    = 8'd175;
  localparam logic [7:0] OpJump            = 8'd181;
  localparam logic [7:0] OpIndirJump       = 8'd182;
  localparam logic [7:0] OpFpuScalar       = 8'hF0;
  localparam logic [7:0] OpSystem          = 8'hFF;

  // Bit 2 of the basic ALU block selects multiply.
  localparam int AluMulSelectBit = 2;

  // Short-form sub-opcodes.
  localparam logic [5:0] SubAluLast        = 6'd19;
  localparam logic [5:0] SubShiftLast      = 6'd31;
  localparam logic [5:0] SubJumpFirst      = 6'd48;
  localparam logic [5:0] SubJumpLast       = 6'd51;
  localparam logic [5:0] SubFpuFirst       = 6'd52;

endpackage
